//--- fir_accel_top.f
+incdir+.
fir_pkg.sv
fir_wb_regs.sv
fir_ctrl_fsm.sv
fir_sample_counter.sv
fir_sample_buffer.sv
fir_filter.sv
fir_accel_top.sv
tb_fir_accel.sv

//--- Makefile
VERILATOR  ?= verilator
FILELIST   := fir_accel_top.f
TOP        := tb_fir_accel
RTL_TOP    := fir_accel_top
LINT_FLAGS := --lint-only --timing -Wno-fatal
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_fir_tasks.svh
// one classic cycle held until ack or err
task automatic wb_cycle(
   input  logic        we,
   input  logic [31:0] adr,
   input  logic [31:0] wdat,
   output logic [31:0] rdat,
   output logic        ok
);
   @(posedge wb_clk_i);
   wb_cyc_i <= 1'b1;
   wb_stb_i <= 1'b1;
   wb_we_i  <= we;
   wb_adr_i <= adr;
   wb_dat_i <= wdat;
   @(posedge wb_clk_i);
   while (!wb_ack_o && !wb_err_o)
      @(posedge wb_clk_i);
   check_value(32'(wb_err_o), 32'(!wb_ack_o), "ack and err exclusive");
   ok   = wb_ack_o;
   rdat = wb_dat_o;
   wb_cyc_i <= 1'b0;
   wb_stb_i <= 1'b0;
   wb_we_i  <= 1'b0;
endtask

task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat, output logic ok);
   logic [31:0] rd_unused;
   wb_cycle(1'b1, adr, dat, rd_unused, ok);
endtask

task automatic wb_read(input logic [31:0] adr, output logic [31:0] dat, output logic ok);
   wb_cycle(1'b0, adr, 32'h0, dat, ok);
endtask

task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
   assert (got === exp) else begin
      $display("ERR %0t ns: %s, got %h expected %h", $time, what, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "check failed");
   end
endtask

task automatic write_expect(input logic [31:0] adr, input logic [31:0] dat,
                            input logic ack_exp, input string what);
   logic ok;
   wb_write(adr, dat, ok);
   check_value(32'(ok), 32'(ack_exp), what);
endtask

task automatic read_expect(input logic [31:0] adr, input logic [31:0] exp, input string what);
   logic [31:0] rd;
   logic        ok;
   wb_read(adr, rd, ok);
   check_value(32'(ok), 32'h1, {what, " ack"});
   check_value(rd, exp, what);
endtask

function automatic logic [31:0] sext16(input logic signed [15:0] v);
   return 32'(v);
endfunction

task automatic randomize_block();
   for (int i = 0; i < `FIR_TAPS; i++)
      coef_mem[i] = 16'($urandom());
   for (int i = 0; i < `FIR_BLOCK_LEN; i++)
      samp_mem[i] = 16'($urandom());
endtask

task automatic load_block();
   for (int i = 0; i < `FIR_TAPS; i++)
      write_expect(`FIR_ADR_COEF_BASE + 32'(4 * i), sext16(coef_mem[i]), 1'b1, "coef write");
   for (int i = 0; i < `FIR_BLOCK_LEN; i++)
      write_expect(`FIR_ADR_IN_BASE + 32'(4 * i), sext16(samp_mem[i]), 1'b1, "sample write");
endtask

// y[k] is the sum of c[t] * x[k-t] with x zero before index 0 and wrapped to 32 bits
task automatic compute_expected();
   logic signed [31:0] acc;
   for (int k = 0; k < `FIR_BLOCK_LEN; k++) begin
      acc = '0;
      for (int t = 0; t < `FIR_TAPS; t++)
         if (k >= t)
            acc = acc + 32'(coef_mem[t]) * 32'(samp_mem[k - t]);
      exp_res[k] = acc;
   end
endtask

task automatic wait_done();
   logic [31:0] st;
   logic        ok;
   int          polls;
   st    = 32'h0;
   polls = 0;
   while (!st[1] && polls < 2 * `FIR_BLOCK_LEN) begin
      wb_read(`FIR_ADR_STATUS, st, ok);
      check_value(32'(ok), 32'h1, "status poll ack");
      // busy alone while running, done alone once the block has finished
      check_value(st, st[1] ? 32'h2 : 32'h1, "status poll value");
      polls++;
   end
   check_value(32'(st[1]), 32'h1, "done within poll limit");
endtask

task automatic check_results();
   compute_expected();
   for (int k = 0; k < `FIR_BLOCK_LEN; k++)
      read_expect(`FIR_ADR_OUT_BASE + 32'(4 * k), exp_res[k], $sformatf("result %0d", k));
endtask

task automatic run_block();
   randomize_block();
   load_block();
   write_expect(`FIR_ADR_CTRL, 32'h1, 1'b1, "start write");
   wait_done();
   check_results();
endtask

task automatic test_reset_readback();
   read_expect(`FIR_ADR_STATUS, 32'h0, "status after reset");
   check_value(32'(int_o), 32'h0, "int_o after reset");
   write_expect(`FIR_ADR_CTRL, 32'h2, 1'b1, "irq enable write");
   read_expect(`FIR_ADR_CTRL, 32'h2, "irq enable readback");
   write_expect(`FIR_ADR_CTRL, 32'h0, 1'b1, "irq disable write");
   read_expect(`FIR_ADR_CTRL, 32'h0, "irq disable readback");
   randomize_block();
   load_block();
   for (int i = 0; i < `FIR_TAPS; i++)
      read_expect(`FIR_ADR_COEF_BASE + 32'(4 * i), sext16(coef_mem[i]), "coef readback");
endtask

task automatic test_impulse();
   randomize_block();
   for (int i = 0; i < `FIR_BLOCK_LEN; i++)
      samp_mem[i] = '0;
   samp_mem[0] = 16'sd1;
   load_block();
   write_expect(`FIR_ADR_CTRL, 32'h1, 1'b1, "start write");
   wait_done();
   // impulse response is the coefficient list followed by zeros
   for (int k = 0; k < `FIR_BLOCK_LEN; k++) begin
      if (k < `FIR_TAPS)
         read_expect(`FIR_ADR_OUT_BASE + 32'(4 * k), sext16(coef_mem[k]), "impulse tap");
      else
         read_expect(`FIR_ADR_OUT_BASE + 32'(4 * k), 32'h0, "impulse tail");
   end
endtask

task automatic test_interrupt();
   int cycles;
   randomize_block();
   load_block();
   write_expect(`FIR_ADR_CTRL, 32'h3, 1'b1, "start with irq enable");
   check_value(32'(int_o), 32'h0, "int_o right after start");
   cycles = 0;
   while (!int_o && cycles < 2 * (`FIR_BLOCK_LEN + 10)) begin
      @(posedge wb_clk_i);
      cycles++;
   end
   check_value(32'(int_o), 32'h1, "int_o before status read");
   read_expect(`FIR_ADR_STATUS, 32'h2, "status with done");
   check_value(32'(int_o), 32'h0, "int_o after status read");
   check_results();
   write_expect(`FIR_ADR_CTRL, 32'h0, 1'b1, "irq disable write");
endtask

task automatic test_errors();
   logic [31:0] rd;
   logic        ok;
   wb_read(32'h0000_0800, rd, ok);
   check_value(32'(ok), 32'h0, "unmapped read ends in err");
   write_expect(`FIR_ADR_STATUS, 32'h3, 1'b0, "status write refused");
   randomize_block();
   load_block();
   write_expect(`FIR_ADR_CTRL, 32'h1, 1'b1, "start write");
   // both land while the block is running
   write_expect(`FIR_ADR_IN_BASE + 32'd20, 32'h0000_7fff, 1'b0, "sample write while busy");
   write_expect(`FIR_ADR_COEF_BASE + 32'd12, 32'h0000_1234, 1'b0, "coef write while busy");
   wait_done();
   check_results();
endtask

//--- tb_fir_accel.sv
`timescale 1ns/1ns
`include "fir_settings.svh"

module tb_fir_accel;

   localparam int          CLK_PERIOD    = 4;
   localparam logic [31:0] SEED          = 32'h5c7d_1825;
   localparam int          BUS_ACCESSES  = 500;
   localparam int          ACCESS_CYCLES = 3;
   localparam int          BLOCKS        = 5;
   localparam int          WATCHDOG_CYCLES =
      2 * (BUS_ACCESSES * ACCESS_CYCLES + BLOCKS * (`FIR_BLOCK_LEN + 10));

   logic        wb_clk_i;
   logic        wb_rst_i;
   logic [31:0] wb_adr_i;
   logic [31:0] wb_dat_i;
   logic [3:0]  wb_sel_i;
   logic        wb_we_i;
   logic        wb_stb_i;
   logic        wb_cyc_i;
   logic [31:0] wb_dat_o;
   logic        wb_ack_o;
   logic        wb_err_o;
   logic        int_o;

   // software side copy of the current block
   logic signed [`FIR_SAMPLE_W-1:0] coef_mem [`FIR_TAPS];
   logic signed [`FIR_SAMPLE_W-1:0] samp_mem [`FIR_BLOCK_LEN];
   logic        [`FIR_RESULT_W-1:0] exp_res  [`FIR_BLOCK_LEN];

   fir_accel_top u_dut (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .wb_adr_i (wb_adr_i),
      .wb_dat_i (wb_dat_i),
      .wb_sel_i (wb_sel_i),
      .wb_we_i  (wb_we_i),
      .wb_stb_i (wb_stb_i),
      .wb_cyc_i (wb_cyc_i),
      .wb_dat_o (wb_dat_o),
      .wb_ack_o (wb_ack_o),
      .wb_err_o (wb_err_o),
      .int_o    (int_o)
   );

   `include "tb_fir_tasks.svh"

   always #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired before the tests finished");
      $display("TESTBENCH FAILED");
      $fatal(1, "timeout");
   end

   initial begin
      void'($urandom(SEED));
      wb_clk_i = 1'b0;
      wb_rst_i = 1'b1;
      wb_adr_i = '0;
      wb_dat_i = '0;
      wb_sel_i = 4'hf;
      wb_we_i  = 1'b0;
      wb_stb_i = 1'b0;
      wb_cyc_i = 1'b0;
      repeat (4) @(posedge wb_clk_i);
      wb_rst_i <= 1'b0;

      test_reset_readback();
      test_impulse();
      // random block, then a second one back to back
      run_block();
      run_block();
      test_interrupt();
      test_errors();

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

//--- fir_accel_top.sv
`timescale 1ns/1ns
`include "fir_settings.svh"

module fir_accel_top import fir_pkg::*; (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic [31:0] wb_adr_i,
   input  logic [31:0] wb_dat_i,
   input  logic [3:0]  wb_sel_i,
   input  logic        wb_we_i,
   input  logic        wb_stb_i,
   input  logic        wb_cyc_i,
   output logic [31:0] wb_dat_o,
   output logic        wb_ack_o,
   output logic        wb_err_o,
   output logic        int_o
);

   fir_ctrl_t                 ctrl;
   fir_status_t               status;
   fir_coef_t                 coef;
   fir_buf_wr_t               in_wr;
   fir_buf_wr_t               res;
   logic [`FIR_IDX_W-1:0]     out_rd_idx;
   logic [`FIR_RESULT_W-1:0]  out_rd_data;
   logic [`FIR_IDX_W-1:0]     in_rd_idx;
   logic [`FIR_SAMPLE_W-1:0]  in_rd_data;
   logic                      count_en;
   logic                      count_clr;
   logic                      filt_en;
   logic                      last;

   fir_wb_regs u_regs (
      .wb_clk_i      (wb_clk_i),
      .wb_rst_i      (wb_rst_i),
      .wb_adr_i      (wb_adr_i),
      .wb_dat_i      (wb_dat_i),
      .wb_sel_i      (wb_sel_i),
      .wb_we_i       (wb_we_i),
      .wb_stb_i      (wb_stb_i),
      .wb_cyc_i      (wb_cyc_i),
      .status_i      (status),
      .out_rd_data_i (out_rd_data),
      .wb_dat_o      (wb_dat_o),
      .wb_ack_o      (wb_ack_o),
      .wb_err_o      (wb_err_o),
      .int_o         (int_o),
      .ctrl_o        (ctrl),
      .coef_o        (coef),
      .in_wr_o       (in_wr),
      .out_rd_idx_o  (out_rd_idx)
   );

   fir_ctrl_fsm u_ctrl (
      .wb_clk_i    (wb_clk_i),
      .wb_rst_i    (wb_rst_i),
      .ctrl_i      (ctrl),
      .last_i      (last),
      .count_en_o  (count_en),
      .count_clr_o (count_clr),
      .filt_en_o   (filt_en),
      .status_o    (status)
   );

   fir_sample_counter u_counter (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .clr_i    (count_clr),
      .en_i     (count_en),
      .idx_o    (in_rd_idx),
      .last_o   (last)
   );

   // samples from the bus, read out by the counter
   fir_sample_buffer #(.DATA_W(`FIR_SAMPLE_W)) u_in_buf (
      .wb_clk_i  (wb_clk_i),
      .wr_i      (in_wr),
      .rd_idx_i  (in_rd_idx),
      .rd_data_o (in_rd_data)
   );

   // results from the filter, read out over the bus
   fir_sample_buffer #(.DATA_W(`FIR_RESULT_W)) u_out_buf (
      .wb_clk_i  (wb_clk_i),
      .wr_i      (res),
      .rd_idx_i  (out_rd_idx),
      .rd_data_o (out_rd_data)
   );

   fir_filter u_filter (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .clr_i    (count_clr),
      .en_i     (filt_en),
      .sample_i (in_rd_data),
      .coef_i   (coef),
      .res_o    (res)
   );

endmodule

//--- fir_filter.sv
`timescale 1ns/1ns
`include "fir_settings.svh"

module fir_filter import fir_pkg::*; (
   input  logic                    wb_clk_i,
   input  logic                    wb_rst_i,
   input  logic                    clr_i,
   input  logic                    en_i,
   input  logic [`FIR_SAMPLE_W-1:0] sample_i,
   input  fir_coef_t               coef_i,
   output fir_buf_wr_t             res_o
);

   localparam int PAIRS = `FIR_TAPS / 2;

   logic signed [`FIR_SAMPLE_W-1:0] hist_q [`FIR_TAPS-1];
   logic signed [`FIR_SAMPLE_W-1:0] win    [`FIR_TAPS];
   logic signed [`FIR_RESULT_W-1:0] prod   [`FIR_TAPS];
   logic signed [`FIR_RESULT_W-1:0] pair_q [PAIRS];
   logic        [`FIR_RESULT_W-1:0] pair_sum;
   logic        [`FIR_RESULT_W-1:0] sum_q;
   logic                            v1_q;
   logic                            v2_q;
   logic        [`FIR_IDX_W-1:0]    out_idx_q;

   // window is the new sample followed by the stored history
   always_comb begin
      win[0] = sample_i;
      for (int i = 1; i < `FIR_TAPS; i++)
         win[i] = hist_q[i-1];
      for (int i = 0; i < `FIR_TAPS; i++)
         prod[i] = win[i] * $signed(coef_i[i]);
   end

   always_comb begin
      pair_sum = '0;
      for (int i = 0; i < PAIRS; i++)
         pair_sum = pair_sum + pair_q[i];
   end

   // history starts from zero on every block
   always_ff @(posedge wb_clk_i) begin
      if (clr_i) begin
         for (int i = 0; i < `FIR_TAPS - 1; i++)
            hist_q[i] <= '0;
      end else if (en_i) begin
         hist_q[0] <= sample_i;
         for (int i = 1; i < `FIR_TAPS - 1; i++)
            hist_q[i] <= hist_q[i-1];
      end
   end

   // two adder stages, sums wrap at the result width
   always_ff @(posedge wb_clk_i) begin
      if (en_i) begin
         for (int i = 0; i < PAIRS; i++)
            pair_q[i] <= prod[2*i] + prod[2*i+1];
      end
      if (v1_q)
         sum_q <= pair_sum;
   end

   // valid and output index follow the data down the pipe
   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i || clr_i) begin
         v1_q      <= 1'b0;
         v2_q      <= 1'b0;
         out_idx_q <= '0;
      end else begin
         v1_q <= en_i;
         v2_q <= v1_q;
         if (v2_q)
            out_idx_q <= out_idx_q + 1'b1;
      end
   end

   assign res_o.en   = v2_q;
   assign res_o.idx  = out_idx_q;
   assign res_o.data = sum_q;

endmodule

//--- fir_sample_buffer.sv
`timescale 1ns/1ns
`include "fir_settings.svh"

module fir_sample_buffer import fir_pkg::*; #(
   parameter int DATA_W = 16
) (
   input  logic                  wb_clk_i,
   input  fir_buf_wr_t           wr_i,
   input  logic [`FIR_IDX_W-1:0] rd_idx_i,
   output logic [DATA_W-1:0]     rd_data_o
);

   logic [DATA_W-1:0] mem [`FIR_BLOCK_LEN];
   logic [DATA_W-1:0] rd_q;

   // one write port, one registered read port
   always_ff @(posedge wb_clk_i) begin
      if (wr_i.en)
         mem[wr_i.idx] <= wr_i.data[DATA_W-1:0];
      rd_q <= mem[rd_idx_i];
   end

   assign rd_data_o = rd_q;

endmodule

//--- fir_sample_counter.sv
`timescale 1ns/1ns
`include "fir_settings.svh"

module fir_sample_counter (
   input  logic                  wb_clk_i,
   input  logic                  wb_rst_i,
   input  logic                  clr_i,
   input  logic                  en_i,
   output logic [`FIR_IDX_W-1:0] idx_o,
   output logic                  last_o
);

   localparam logic [`FIR_IDX_W-1:0] LAST_IDX = `FIR_IDX_W'(`FIR_BLOCK_LEN - 1);

   logic [`FIR_IDX_W-1:0] idx_q;

   // holds at the final index until the next start
   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i)
         idx_q <= '0;
      else if (clr_i)
         idx_q <= '0;
      else if (en_i && idx_q != LAST_IDX)
         idx_q <= idx_q + 1'b1;
   end

   assign idx_o  = idx_q;
   assign last_o = (idx_q == LAST_IDX);

endmodule

//--- fir_ctrl_fsm.sv
`timescale 1ns/1ns
`include "fir_settings.svh"

module fir_ctrl_fsm import fir_pkg::*; (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  fir_ctrl_t   ctrl_i,
   input  logic        last_i,
   output logic        count_en_o,
   output logic        count_clr_o,
   output logic        filt_en_o,
   output fir_status_t status_o
);

   localparam int DRAIN_W = $clog2(`FIR_PIPE_LAT + 1);

   fir_state_e         state_q;
   fir_state_e         state_d;
   logic [DRAIN_W-1:0] drain_q;
   logic               filt_en_q;

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE:  if (ctrl_i.start) state_d = ST_FEED;
         ST_FEED:  if (last_i) state_d = ST_DRAIN;
         ST_DRAIN: if (drain_q == DRAIN_W'(`FIR_PIPE_LAT - 1)) state_d = ST_DONE;
         ST_DONE:  state_d = ST_IDLE;
         default:  state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         state_q   <= ST_IDLE;
         drain_q   <= '0;
         filt_en_q <= 1'b0;
      end else begin
         state_q <= state_d;
         // filter runs one cycle behind the counter, matching the buffer read
         filt_en_q <= (state_q == ST_FEED);
         if (state_q == ST_DRAIN)
            drain_q <= drain_q + 1'b1;
         else
            drain_q <= '0;
      end
   end

   // start clears counter and filter history together
   assign count_clr_o = (state_q == ST_IDLE) & ctrl_i.start;
   assign count_en_o  = (state_q == ST_FEED);
   assign filt_en_o   = filt_en_q;

   assign status_o.busy = (state_q != ST_IDLE);
   assign status_o.done = (state_q == ST_DONE);

endmodule

//--- fir_wb_regs.sv
`timescale 1ns/1ns
`include "fir_settings.svh"

module fir_wb_regs import fir_pkg::*; (
   input  logic                  wb_clk_i,
   input  logic                  wb_rst_i,
   input  logic [31:0]           wb_adr_i,
   input  logic [31:0]           wb_dat_i,
   // byte selects are ignored, every write is a full word
   input  logic [3:0]            wb_sel_i,
   input  logic                  wb_we_i,
   input  logic                  wb_stb_i,
   input  logic                  wb_cyc_i,
   input  fir_status_t           status_i,
   input  logic [31:0]           out_rd_data_i,
   output logic [31:0]           wb_dat_o,
   output logic                  wb_ack_o,
   output logic                  wb_err_o,
   output logic                  int_o,
   output fir_ctrl_t             ctrl_o,
   output fir_coef_t             coef_o,
   output fir_buf_wr_t           in_wr_o,
   output logic [`FIR_IDX_W-1:0] out_rd_idx_o
);

   localparam int COEF_LSB = $clog2(`FIR_TAPS) + 2;
   localparam int BUF_LSB  = $clog2(`FIR_BLOCK_LEN) + 2;

   localparam logic [31:0] COEF_BASE = `FIR_ADR_COEF_BASE;
   localparam logic [31:0] IN_BASE   = `FIR_ADR_IN_BASE;
   localparam logic [31:0] OUT_BASE  = `FIR_ADR_OUT_BASE;

   fir_reg_op_e           op;
   fir_reg_op_e           op_q;
   logic                  req;
   logic                  bad;
   logic                  ack_q;
   logic                  err_q;
   logic                  start_q;
   logic                  irq_en_q;
   logic                  done_q;
   logic [31:0]           rd_q;
   logic [COEF_LSB-3:0]   coef_idx;
   fir_coef_t             coef_q;

   // address decode, misaligned accesses fall through to invalid
   always_comb begin
      op = OP_INVALID;
      if (wb_adr_i[1:0] == 2'b00) begin
         if (wb_adr_i == `FIR_ADR_CTRL)
            op = OP_CTRL;
         else if (wb_adr_i == `FIR_ADR_STATUS)
            op = OP_STATUS;
         else if (wb_adr_i[31:COEF_LSB] == COEF_BASE[31:COEF_LSB])
            op = OP_COEF;
         else if (wb_adr_i[31:BUF_LSB] == IN_BASE[31:BUF_LSB])
            op = OP_IN_BUF;
         else if (wb_adr_i[31:BUF_LSB] == OUT_BASE[31:BUF_LSB])
            op = OP_OUT_BUF;
      end
   end

   // new request only when no ack or err is on the bus
   assign req = wb_cyc_i & wb_stb_i & ~ack_q & ~err_q;

   assign bad = (op == OP_INVALID)
              | (wb_we_i & ((op == OP_STATUS) | (op == OP_OUT_BUF)))
              | (wb_we_i & status_i.busy & ((op == OP_COEF) | (op == OP_IN_BUF)));

   assign coef_idx = wb_adr_i[COEF_LSB-1:2];

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         ack_q    <= 1'b0;
         err_q    <= 1'b0;
         start_q  <= 1'b0;
         irq_en_q <= 1'b0;
         done_q   <= 1'b0;
      end else begin
         ack_q   <= req & ~bad;
         err_q   <= req & bad;
         start_q <= req & wb_we_i & (op == OP_CTRL) & wb_dat_i[0] & ~status_i.busy;
         if (req & wb_we_i & (op == OP_CTRL))
            irq_en_q <= wb_dat_i[1];
         // a finishing block wins over a status read in the same cycle
         if (status_i.done)
            done_q <= 1'b1;
         else if (req & ~wb_we_i & (op == OP_STATUS))
            done_q <= 1'b0;
      end
   end

   // read data is captured at decode so a status read sees done before it clears
   always_ff @(posedge wb_clk_i) begin
      if (req) begin
         op_q <= op;
         case (op)
            OP_CTRL:   rd_q <= {30'b0, irq_en_q, 1'b0};
            OP_STATUS: rd_q <= {30'b0, done_q, status_i.busy};
            OP_COEF:   rd_q <= 32'(signed'(coef_q[coef_idx]));
            default:   rd_q <= 32'b0;
         endcase
      end
      if (req & wb_we_i & (op == OP_COEF) & ~status_i.busy)
         coef_q[coef_idx] <= wb_dat_i[`FIR_SAMPLE_W-1:0];
   end

   // input buffer is written straight from the bus
   assign in_wr_o.en   = req & wb_we_i & (op == OP_IN_BUF) & ~status_i.busy;
   assign in_wr_o.idx  = wb_adr_i[BUF_LSB-1:2];
   assign in_wr_o.data = wb_dat_i;

   // output buffer read is registered, data lands in the ack cycle
   assign out_rd_idx_o = wb_adr_i[BUF_LSB-1:2];

   assign wb_dat_o = (op_q == OP_OUT_BUF) ? out_rd_data_i : rd_q;
   assign wb_ack_o = ack_q;
   assign wb_err_o = err_q;
   assign int_o    = done_q & irq_en_q;

   assign ctrl_o.start  = start_q;
   assign ctrl_o.irq_en = irq_en_q;
   assign coef_o        = coef_q;

endmodule

//--- fir_pkg.sv
`include "fir_settings.svh"

package fir_pkg;

   // controller sequence for one block
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_FEED,
      ST_DRAIN,
      ST_DONE
   } fir_state_e;

   // decoded bus access kind
   typedef enum logic [2:0] {
      OP_CTRL,
      OP_STATUS,
      OP_COEF,
      OP_IN_BUF,
      OP_OUT_BUF,
      OP_INVALID
   } fir_reg_op_e;

   // register block to controller
   typedef struct packed {
      logic start;
      logic irq_en;
   } fir_ctrl_t;

   // controller back to register block
   typedef struct packed {
      logic busy;
      logic done;
   } fir_status_t;

   // write port of either sample buffer
   typedef struct packed {
      logic                     en;
      logic [`FIR_IDX_W-1:0]    idx;
      logic [`FIR_RESULT_W-1:0] data;
   } fir_buf_wr_t;

   typedef logic [`FIR_TAPS-1:0][`FIR_SAMPLE_W-1:0] fir_coef_t;

endpackage

//--- fir_settings.svh
`ifndef FIR_SETTINGS_SVH
`define FIR_SETTINGS_SVH

// filter geometry
`define FIR_TAPS       8
`define FIR_BLOCK_LEN  32
`define FIR_IDX_W      5

// data widths
`define FIR_SAMPLE_W   16
`define FIR_RESULT_W   32

// sample in to result out through the adder tree
`define FIR_PIPE_LAT   2

// word aligned byte addresses of the register map
`define FIR_ADR_CTRL       32'h0000_0000
`define FIR_ADR_STATUS     32'h0000_0004
`define FIR_ADR_COEF_BASE  32'h0000_0040
`define FIR_ADR_IN_BASE    32'h0000_0100
`define FIR_ADR_OUT_BASE   32'h0000_0200

`endif
